// File: test/conv_trace.txt
# command: C L addr data | C R ifm_base weight_base window_words num_outputs stride | C N
# E expected result word as index then act3 down to act0 | W waits for busy to fall
C L 00 0a0a0a0a
C L 01 14141414
C L 02 fbfbfbfb
C L 03 1e1e1e1e
C L 40 01010101
C L 41 01010101
C L 42 02020202
C L 43 ffffffff
C L 44 fdfdfdfd
C L 45 00000000
C L 46 14141414
C L 47 14141414
C R 00 40 2 3 1
E 0060000007
E 014b000b03
E 0260030006
C L 80 10101010
C L 82 f0f0f0f0
C L 84 05050505
C L 86 00000000
C L 88 64646464
C L 8a 80808080
C L c0 04030201
C L c1 fffefdfc
C L c2 08080808
C L c3 7f7f7f7f
C N
C R 80 c0 1 6 2
E 006020000a
E 0100000a00
E 02600a0003
E 0300000000
E 046060003e
E 0500005000
W

// File: src.f
+incdir+common
common/host_pkg.sv
common/datapath_pkg.sv
logic/scratchpad.sv
logic/host_loader.sv
conv/conv_sequencer.sv
conv/pe_cluster.sv
conv/output_port.sv
logic/conv_top.sv
test/conv_props.sv
test/conv_tb.sv

// File: run_sim.sh
#!/bin/sh
# Verilator build and run of the conv testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_tb -f src.f -o conv_sim

./obj_dir/conv_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TB FAILED" sim.log; then
    exit 1
fi
exit 0

// File: test/conv_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_tb;
    import host_pkg::*;
    import datapath_pkg::*;

    logic         clk;
    logic         reset;
    logic         cmd_valid;
    host_cmd_t    cmd;
    logic         cmd_credit;
    logic         out_valid;
    conv_result_t out_word;
    logic         out_credit;
    logic         busy;

    conv_result_t exp_q[$];
    conv_result_t expected;
    integer       errors = 0;
    integer       n_sent = 0;
    integer       n_cmd_cred = 0;
    integer       n_runs = 0;
    integer       n_starts = 0;
    integer       n_out = 0;
    integer       n_ret = 0;
    integer       owed = 0;
    integer       wait_left = 0;
    integer       limit_cycles = 0;
    logic         busy_prev = 1'b0;

    conv_top i_conv_top (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .out_valid  (out_valid),
        .out_word   (out_word),
        .out_credit (out_credit),
        .busy       (busy)
    );

    always #5 clk = ~clk;

    // one host step that also counts credits and job starts
    task automatic tick();
        @(negedge clk);
        if (cmd_credit) begin
            n_cmd_cred++;
        end
        if (busy && !busy_prev) begin
            n_starts++;
        end
        busy_prev = busy;
    endtask

    task automatic send_cmd(input host_cmd_t c);
        while (n_sent - n_cmd_cred >= `CMD_QUEUE_DEPTH) begin
            tick();
        end
        cmd       = c;
        cmd_valid = 1'b1;
        n_sent++;
        if (c.op == CMD_RUN) begin
            n_runs++;
        end
        tick();
        cmd_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (!(n_starts == n_runs && !busy)) begin
            tick();
        end
    endtask

    // result checks and credit return
    always @(negedge clk) begin
        if (!reset) begin
            if (out_valid) begin
                n_out++;
                if (n_out > `OUT_CREDITS + n_ret) begin
                    errors++;
                    $display("** Error at %0t: out_valid beyond returned credits", $time);
                end
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("** Error at %0t: unexpected result word %h", $time, out_word);
                end else begin
                    expected = exp_q.pop_front();
                    if (out_word !== expected) begin
                        errors++;
                        $display("** Error at %0t: result got %h expected %h",
                                 $time, out_word, expected);
                    end
                end
                owed++;
            end
            out_credit = 1'b0;
            if (owed > 0) begin
                if (wait_left > 0) begin
                    wait_left--;
                end else begin
                    out_credit = 1'b1;
                    owed--;
                    n_ret++;
                    wait_left = $urandom % 7;
                    // long gap so the result fifo fills up
                    if (n_ret == 3) begin
                        wait_left = wait_left + 60;
                    end
                end
            end
        end
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("run timed out after %0d cycles", limit_cycles);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        integer             fd;
        integer             code;
        integer             n_cmds;
        integer             seed;
        logic               done;
        logic [8*8-1:0]     kind;
        logic [8*8-1:0]     sub;
        logic [8*160-1:0]   line;
        logic [31:0]        a;
        logic [31:0]        b;
        logic [31:0]        c;
        logic [31:0]        d;
        logic [31:0]        e;
        logic [39:0]        value;
        host_cmd_t          hc;

        seed       = $urandom(89222);
        clk        = 1'b0;
        reset      = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = '0;
        out_credit = 1'b0;

        fd = $fopen("test/conv_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open the trace file");
            $display("TB FAILED");
            $finish;
        end else begin
            // first pass sizes the watchdog
            n_cmds = 0;
            done   = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    code = $fgets(line, fd);
                end else if (kind == "C") begin
                    n_cmds++;
                end
            end
            $fclose(fd);
            limit_cycles = n_cmds * 200;

            repeat (16) @(negedge clk);
            reset = 1'b0;

            // idle outputs before any command
            repeat (8) begin
                tick();
                if (out_valid || cmd_credit || busy) begin
                    errors++;
                    $display("** Error at %0t: output active before any command", $time);
                end
            end

            fd   = $fopen("test/conv_trace.txt", "r");
            done = 1'b0;
            while (!done) begin
                code = $fscanf(fd, "%s", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else if (kind == "#") begin
                    code = $fgets(line, fd);
                end else if (kind == "C") begin
                    code = $fscanf(fd, "%s", sub);
                    hc   = '0;
                    if (sub == "L") begin
                        code = $fscanf(fd, "%h %h", a, b);
                        hc.op                = CMD_LOAD;
                        hc.payload.load.addr = a[7:0];
                        hc.payload.load.data = b;
                    end else if (sub == "R") begin
                        code = $fscanf(fd, "%h %h %h %h %h", a, b, c, d, e);
                        hc.op                       = CMD_RUN;
                        hc.payload.run.ifm_base     = a[7:0];
                        hc.payload.run.weight_base  = b[7:0];
                        hc.payload.run.window_words = c[3:0];
                        hc.payload.run.num_outputs  = d[7:0];
                        hc.payload.run.stride       = e[1:0];
                    end else begin
                        hc.op = CMD_NOP;
                    end
                    send_cmd(hc);
                end else if (kind == "E") begin
                    code = $fscanf(fd, "%h", value);
                    exp_q.push_back(conv_result_t'(value));
                end else if (kind == "W") begin
                    wait_idle();
                end else begin
                    errors++;
                    $display("unknown entry in the trace file");
                end
            end
            $fclose(fd);

            while (exp_q.size() != 0) begin
                tick();
            end
            repeat (20) tick();
            if (n_cmd_cred != n_sent) begin
                errors++;
                $display("command credits returned %0d but %0d commands sent",
                         n_cmd_cred, n_sent);
            end

            $display("errors: %0d, results: %0d, commands: %0d", errors, n_out, n_sent);
            if (errors == 0) begin
                $display("TB PASSED");
            end else begin
                $display("TB FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: test/conv_props.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_props (
    input wire logic                                  clk,
    input wire logic                                  reset,
    input wire logic                                  out_valid,
    input wire logic                                  result_valid,
    input wire logic [$clog2(`OUT_FIFO_DEPTH):0]      count,
    input wire logic [$clog2(`OUT_CREDITS + 1)-1:0]   credits
);

    // credit counter stays within its reset value
    credit_bound: assert property (@(posedge clk) disable iff (reset)
        credits <= `OUT_CREDITS)
        else $error("output credit count above its limit");

    credit_needed: assert property (@(posedge clk) disable iff (reset)
        out_valid |-> credits != '0)
        else $error("out_valid with no output credit");

    // slot reservation upstream must keep the fifo from overflowing
    fifo_no_overflow: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (count < `OUT_FIFO_DEPTH) || out_valid)
        else $error("result written into a full fifo");

endmodule

bind output_port conv_props i_conv_props (
    .clk          (clk),
    .reset        (reset),
    .out_valid    (out_valid),
    .result_valid (result_valid),
    .count        (count),
    .credits      (credits)
);

`default_nettype wire

// File: logic/conv_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_top (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        cmd_valid,
    input  wire host_pkg::host_cmd_t         cmd,
    output logic                             cmd_credit,
    output logic                             out_valid,
    output datapath_pkg::conv_result_t       out_word,
    input  wire logic                        out_credit,
    output logic                             busy
);
    import host_pkg::*;
    import datapath_pkg::*;

    mem_req_t                  loader_req;
    mem_req_t                  seq_req;
    logic                      loader_grant;
    logic                      seq_grant;
    mem_word_t                 rd_data;
    logic                      rd_valid;
    logic                      job_start;
    run_payload_t              job;
    logic                      slot_free;
    mem_word_t                 pe_ifm;
    mem_word_t [`NUM_PE-1:0]   pe_weight;
    logic [7:0]                pe_index;
    logic                      pe_step_valid;
    logic                      pe_first;
    logic                      pe_last;
    logic                      result_valid;
    conv_result_t              result;

    host_loader i_host_loader (
        .clk        (clk),
        .reset      (reset),
        .cmd_valid  (cmd_valid),
        .cmd        (cmd),
        .cmd_credit (cmd_credit),
        .mem_req    (loader_req),
        .mem_grant  (loader_grant),
        .busy       (busy),
        .job_start  (job_start),
        .job        (job)
    );

    // loader is port a so it wins the first conflict
    scratchpad i_scratchpad (
        .clk      (clk),
        .reset    (reset),
        .req_a    (loader_req),
        .req_b    (seq_req),
        .grant_a  (loader_grant),
        .grant_b  (seq_grant),
        .rd_data  (rd_data),
        .rd_valid (rd_valid)
    );

    conv_sequencer i_conv_sequencer (
        .clk           (clk),
        .reset         (reset),
        .job_start     (job_start),
        .job           (job),
        .busy          (busy),
        .mem_req       (seq_req),
        .mem_grant     (seq_grant),
        .rd_data       (rd_data),
        .rd_valid      (rd_valid),
        .slot_free     (slot_free),
        .pe_ifm        (pe_ifm),
        .pe_weight     (pe_weight),
        .pe_index      (pe_index),
        .pe_step_valid (pe_step_valid),
        .pe_first      (pe_first),
        .pe_last       (pe_last)
    );

    pe_cluster i_pe_cluster (
        .clk           (clk),
        .reset         (reset),
        .pe_ifm        (pe_ifm),
        .pe_weight     (pe_weight),
        .pe_index      (pe_index),
        .pe_step_valid (pe_step_valid),
        .pe_first      (pe_first),
        .pe_last       (pe_last),
        .result_valid  (result_valid),
        .result        (result)
    );

    output_port i_output_port (
        .clk          (clk),
        .reset        (reset),
        .result_valid (result_valid),
        .result       (result),
        .slot_free    (slot_free),
        .out_valid    (out_valid),
        .out_word     (out_word),
        .out_credit   (out_credit)
    );

endmodule

`default_nettype wire

// File: conv/output_port.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module output_port (
    input  wire logic                        clk,
    input  wire logic                        reset,
    input  wire logic                        result_valid,
    input  wire datapath_pkg::conv_result_t  result,
    output logic                             slot_free,
    output logic                             out_valid,
    output datapath_pkg::conv_result_t       out_word,
    input  wire logic                        out_credit
);
    import datapath_pkg::*;

    localparam int PTR_BITS  = $clog2(`OUT_FIFO_DEPTH);
    localparam int CRED_BITS = $clog2(`OUT_CREDITS + 1);
    // room for the new position plus one still in flight
    localparam logic [PTR_BITS:0] FREE_LIMIT = `OUT_FIFO_DEPTH - 2;

    conv_result_t         fifo [`OUT_FIFO_DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [PTR_BITS:0]    count;
    logic [CRED_BITS-1:0] credits;

    assign out_valid = (credits != '0) && (count != '0);
    assign out_word  = fifo[rd_ptr];
    assign slot_free = (count <= FREE_LIMIT);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            count   <= '0;
            credits <= CRED_BITS'(`OUT_CREDITS);
        end else begin
            if (result_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (out_valid) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({result_valid, out_valid})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({out_credit, out_valid})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (result_valid) begin
            fifo[wr_ptr] <= result;
        end
    end

endmodule

`default_nettype wire

// File: conv/pe_cluster.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module pe_cluster (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire datapath_pkg::mem_word_t             pe_ifm,
    input  wire datapath_pkg::mem_word_t [`NUM_PE-1:0] pe_weight,
    input  wire logic [7:0]                          pe_index,
    input  wire logic                                pe_step_valid,
    input  wire logic                                pe_first,
    input  wire logic                                pe_last,
    output logic                                     result_valid,
    output datapath_pkg::conv_result_t               result
);
    import datapath_pkg::*;

    acc_t acc [`NUM_PE];
    acc_t sum [`NUM_PE];

    // arithmetic shift then clamp to 0..RELU6_MAX
    function automatic logic [7:0] relu6(acc_t value);
        acc_t scaled;
        scaled = value >>> `ACC_SHIFT;
        if (scaled < 0) begin
            return 8'd0;
        end
        if (scaled > `RELU6_MAX) begin
            return 8'(`RELU6_MAX);
        end
        return scaled[7:0];
    endfunction

    always_comb begin
        for (int f = 0; f < `NUM_PE; f++) begin
            sum[f] = pe_first ? '0 : acc[f];
            for (int l = 0; l < `LANES; l++) begin
                sum[f] = sum[f] + acc_t'($signed(pe_ifm[l])) * acc_t'($signed(pe_weight[f][l]));
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= pe_step_valid && pe_last;
        end
    end

    always_ff @(posedge clk) begin
        if (pe_step_valid) begin
            for (int f = 0; f < `NUM_PE; f++) begin
                acc[f] <= sum[f];
            end
        end
        if (pe_step_valid && pe_last) begin
            result.out_index <= pe_index;
            for (int f = 0; f < `NUM_PE; f++) begin
                result.act[f] <= relu6(sum[f]);
            end
        end
    end

endmodule

`default_nettype wire

// File: conv/conv_sequencer.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module conv_sequencer (
    input  wire logic                                clk,
    input  wire logic                                reset,
    input  wire logic                                job_start,
    input  wire host_pkg::run_payload_t              job,
    output logic                                     busy,
    output datapath_pkg::mem_req_t                   mem_req,
    input  wire logic                                mem_grant,
    input  wire datapath_pkg::mem_word_t             rd_data,
    input  wire logic                                rd_valid,
    input  wire logic                                slot_free,
    output datapath_pkg::mem_word_t                  pe_ifm,
    output datapath_pkg::mem_word_t [`NUM_PE-1:0]    pe_weight,
    output logic [7:0]                               pe_index,
    output logic                                     pe_step_valid,
    output logic                                     pe_first,
    output logic                                     pe_last
);
    import host_pkg::*;
    import datapath_pkg::*;

    localparam int AW        = `MEM_ADDR_BITS;
    localparam int PE_BITS   = $clog2(`NUM_PE);
    localparam int SLOT_BITS = $clog2(`NUM_PE + 1);
    localparam logic [SLOT_BITS-1:0] LAST_SLOT = SLOT_BITS'(`NUM_PE);

    typedef enum logic [1:0] {
        S_IDLE,
        S_WAIT,
        S_ISSUE,
        S_DRAIN
    } state_t;

    state_t               state;
    run_payload_t         cfg;
    logic [7:0]           out_idx;
    logic [3:0]           step;
    // slot 0 is the ifm word, slot f+1 the weight of filter f
    logic [SLOT_BITS-1:0] slot;
    logic [AW-1:0]        ifm_addr;
    logic [AW-1:0]        w_addr;
    logic                 step_end;
    logic                 pos_end;
    logic [SLOT_BITS-1:0] tag_slot;
    logic                 tag_first;
    logic                 tag_last;
    logic [7:0]           tag_index;
    logic                 done_q;

    assign ifm_addr = cfg.ifm_base + AW'(out_idx * 8'(cfg.stride)) + AW'(step);
    assign w_addr   = cfg.weight_base + AW'(slot - 1'b1) * AW'(cfg.window_words) + AW'(step);
    assign step_end = (step == cfg.window_words - 4'd1);
    assign pos_end  = (slot == LAST_SLOT) && step_end;

    always_comb begin
        mem_req.valid = (state == S_ISSUE);
        mem_req.write = 1'b0;
        mem_req.addr  = (slot == '0) ? ifm_addr : w_addr;
        mem_req.data  = '0;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state         <= S_IDLE;
            busy          <= 1'b0;
            out_idx       <= '0;
            step          <= '0;
            slot          <= '0;
            done_q        <= 1'b0;
            pe_step_valid <= 1'b0;
        end else begin
            pe_step_valid <= rd_valid && (tag_slot == LAST_SLOT);
            // high while the final result enters the fifo
            done_q        <= (state == S_DRAIN) && pe_step_valid && pe_last;
            case (state)
                S_IDLE: begin
                    if (job_start) begin
                        busy    <= 1'b1;
                        out_idx <= '0;
                        step    <= '0;
                        slot    <= '0;
                        state   <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (slot_free) begin
                        state <= S_ISSUE;
                    end
                end
                S_ISSUE: begin
                    if (mem_grant) begin
                        slot <= (slot == LAST_SLOT) ? '0 : slot + 1'b1;
                        if (slot == LAST_SLOT) begin
                            step <= step_end ? '0 : step + 1'b1;
                        end
                        if (pos_end) begin
                            out_idx <= out_idx + 1'b1;
                            if (out_idx == cfg.num_outputs - 8'd1) begin
                                state <= S_DRAIN;
                            end else begin
                                state <= S_WAIT;
                            end
                        end
                    end
                end
                default: begin
                    if (done_q) begin
                        busy  <= 1'b0;
                        state <= S_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && job_start) begin
            cfg <= job;
        end
        if (mem_grant) begin
            tag_slot  <= slot;
            tag_first <= (step == '0);
            tag_last  <= pos_end;
            tag_index <= out_idx;
        end
        if (rd_valid) begin
            if (tag_slot == '0) begin
                pe_ifm <= rd_data;
            end else begin
                pe_weight[PE_BITS'(tag_slot - 1'b1)] <= rd_data;
            end
            pe_first <= tag_first;
            pe_last  <= tag_last;
            pe_index <= tag_index;
        end
    end

endmodule

`default_nettype wire

// File: logic/host_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module host_loader (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire logic                    cmd_valid,
    input  wire host_pkg::host_cmd_t     cmd,
    output logic                         cmd_credit,
    output datapath_pkg::mem_req_t       mem_req,
    input  wire logic                    mem_grant,
    input  wire logic                    busy,
    output logic                         job_start,
    output host_pkg::run_payload_t       job
);
    import host_pkg::*;

    localparam int PTR_BITS = $clog2(`CMD_QUEUE_DEPTH);

    host_cmd_t           queue [`CMD_QUEUE_DEPTH];
    host_cmd_t           head;
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [PTR_BITS:0]   count;
    logic                pending;
    logic                retire;

    assign head    = queue[rd_ptr];
    assign pending = (count != '0);

    always_comb begin
        mem_req.valid = pending && (head.op == CMD_LOAD);
        mem_req.write = 1'b1;
        mem_req.addr  = head.payload.load.addr;
        mem_req.data  = head.payload.load.data;
        job_start     = pending && (head.op == CMD_RUN) && !busy;
        job           = head.payload.run;
        case (head.op)
            CMD_LOAD: retire = pending && mem_grant;
            CMD_RUN:  retire = job_start;
            // nop and unknown codes drop out at once
            default:  retire = pending;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            cmd_credit <= 1'b0;
        end else begin
            cmd_credit <= retire;
            if (cmd_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (retire) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({cmd_valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            queue[wr_ptr] <= cmd;
        end
    end

endmodule

`default_nettype wire

// File: logic/scratchpad.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_macros.svh"

module scratchpad (
    input  wire logic                    clk,
    input  wire logic                    reset,
    input  wire datapath_pkg::mem_req_t  req_a,
    input  wire datapath_pkg::mem_req_t  req_b,
    output logic                         grant_a,
    output logic                         grant_b,
    output datapath_pkg::mem_word_t      rd_data,
    output logic                         rd_valid
);
    import datapath_pkg::*;

    mem_word_t mem [`MEM_DEPTH];
    mem_req_t  sel;
    logic      prio_b;

    // b wins a conflict only when it is its turn
    assign grant_a = req_a.valid && (!req_b.valid || !prio_b);
    assign grant_b = req_b.valid && !grant_a;

    always_comb begin
        sel = grant_a ? req_a : req_b;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            prio_b   <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            if (grant_a) begin
                prio_b <= 1'b1;
            end else if (grant_b) begin
                prio_b <= 1'b0;
            end
            rd_valid <= (grant_a || grant_b) && !sel.write;
        end
    end

    always_ff @(posedge clk) begin
        if ((grant_a || grant_b) && sel.write) begin
            mem[sel.addr] <= sel.data;
        end
        rd_data <= mem[sel.addr];
    end

endmodule

`default_nettype wire

// File: common/datapath_pkg.sv
`default_nettype none

`include "conv_macros.svh"

package datapath_pkg;

    typedef logic signed [`WORD_BITS/`LANES-1:0] lane_t;

    // lane 0 in the low byte
    typedef lane_t [`LANES-1:0] mem_word_t;

    typedef logic signed [31:0] acc_t;

    typedef struct packed {
        logic                      valid;
        logic                      write;
        logic [`MEM_ADDR_BITS-1:0] addr;
        mem_word_t                 data;
    } mem_req_t;

    typedef struct packed {
        logic [7:0]                 out_index;
        logic [`NUM_PE-1:0][7:0]    act;
    } conv_result_t;

endpackage

`default_nettype wire

// File: common/host_pkg.sv
`default_nettype none

`include "conv_macros.svh"

package host_pkg;

    localparam int PAYLOAD_BITS = 46;

    typedef enum logic [1:0] {
        CMD_NOP  = 2'd0,
        CMD_LOAD = 2'd1,
        CMD_RUN  = 2'd2
    } cmd_op_t;

    typedef struct packed {
        logic [`MEM_ADDR_BITS-1:0]                          addr;
        logic [`WORD_BITS-1:0]                              data;
        logic [PAYLOAD_BITS-`MEM_ADDR_BITS-`WORD_BITS-1:0] pad;
    } load_payload_t;

    typedef struct packed {
        logic [`MEM_ADDR_BITS-1:0]               ifm_base;
        logic [`MEM_ADDR_BITS-1:0]               weight_base;
        logic [3:0]                              window_words;
        logic [7:0]                              num_outputs;
        logic [1:0]                              stride;
        logic [PAYLOAD_BITS-2*`MEM_ADDR_BITS-15:0] pad;
    } run_payload_t;

    // decoded by opcode
    typedef union packed {
        load_payload_t load;
        run_payload_t  run;
    } cmd_payload_u;

    typedef struct packed {
        cmd_op_t      op;
        cmd_payload_u payload;
    } host_cmd_t;

endpackage

`default_nettype wire

// File: common/conv_macros.svh
`ifndef CONV_MACROS_SVH
`define CONV_MACROS_SVH

// scratchpad geometry
`define WORD_BITS       32
`define LANES           4
`define MEM_DEPTH       256
`define MEM_ADDR_BITS   8

`define NUM_PE          4

// queue and stream sizing
`define CMD_QUEUE_DEPTH 4
`define OUT_FIFO_DEPTH  4
`define OUT_CREDITS     2

// activation scaling with 96 as 6.0 in 4.4 fixed point
`define ACC_SHIFT       4
`define RELU6_MAX       96

`endif
